// ==== src/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

  localparam int XLEN = 32;
  localparam int REG_AW = 5;

  // Stage 0 takes the ALU result, stage 2 drives writeback
  localparam int COMP_STAGES = 3;

  // The product lands in the completion stage with this index
  localparam int MUL_STAGES = 2;

  localparam int DIV_CNT_W = $clog2(XLEN + 1);
  localparam int SHAMT_W = $clog2(XLEN);

  typedef logic [XLEN-1:0] data_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  typedef enum logic [3:0]
  {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SLT  = 4'd7,
    OP_MUL  = 4'd8,
    OP_DIVU = 4'd9,
    OP_REMU = 4'd10
  } op_e;

  typedef enum logic [1:0]
  {
    DIV_IDLE = 2'd0,
    DIV_BUSY = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

// ==== src/calc_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Reservation register contents, one instruction per valid cycle
interface issue_if;
  import calc_pkg::*;

  logic      v;
  op_e       op;
  reg_addr_t rd;
  data_t     rs1_data;
  data_t     rs2_data;

  modport src (output v, op, rd, rs1_data, rs2_data);
  modport dst (input v, op, rd, rs1_data, rs2_data);
endinterface

// Next values of the completion stages, index 0 is the youngest
interface fwd_if;
  import calc_pkg::*;

  logic      [COMP_STAGES-1:0] v;
  reg_addr_t [COMP_STAGES-1:0] rd;
  data_t     [COMP_STAGES-1:0] data;

  modport src (output v, rd, data);
  modport dst (input v, rd, data);
endinterface

// Long latency result, held until yumi
interface long_wb_if;
  import calc_pkg::*;

  logic      v;
  reg_addr_t rd;
  data_t     data;
  logic      yumi;

  modport src (output v, rd, data, input yumi);
  modport dst (input v, rd, data, output yumi);
endinterface

`default_nettype wire

// ==== src/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                dispatch_v_i,
  input  calc_pkg::op_e       dispatch_op_i,
  input  calc_pkg::reg_addr_t dispatch_rd_i,
  input  calc_pkg::reg_addr_t dispatch_rs1_addr_i,
  input  calc_pkg::reg_addr_t dispatch_rs2_addr_i,
  input  calc_pkg::data_t     dispatch_rs1_data_i,
  input  calc_pkg::data_t     dispatch_rs2_data_i,
  input  logic                div_busy_i,
  fwd_if.dst                  fwd,
  issue_if.src                iss
);
  import calc_pkg::*;

  data_t rs1_byp;
  data_t rs2_byp;
  logic  disp_div;
  logic  div_pend_r;

  // Walk from the oldest source so the youngest match wins
  function automatic data_t pick_operand
  (
    input reg_addr_t                   addr,
    input data_t                       rf_data,
    input logic      [COMP_STAGES-1:0] src_v,
    input reg_addr_t [COMP_STAGES-1:0] src_rd,
    input data_t     [COMP_STAGES-1:0] src_data
  );
    data_t sel;
    sel = rf_data;
    for (int i = COMP_STAGES - 1; i >= 0; i--)
    begin
      if (src_v[i] && (src_rd[i] == addr))
      begin
        sel = src_data[i];
      end
    end
    return sel;
  endfunction

  assign rs1_byp = pick_operand(dispatch_rs1_addr_i, dispatch_rs1_data_i,
                                fwd.v, fwd.rd, fwd.data);
  assign rs2_byp = pick_operand(dispatch_rs2_addr_i, dispatch_rs2_data_i,
                                fwd.v, fwd.rd, fwd.data);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      iss.v <= 1'b0;
    end
    else
    begin
      iss.v <= dispatch_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    iss.op       <= dispatch_op_i;
    iss.rd       <= dispatch_rd_i;
    iss.rs1_data <= rs1_byp;
    iss.rs2_data <= rs2_byp;
  end

  assign disp_div = dispatch_v_i && ((dispatch_op_i == OP_DIVU) || (dispatch_op_i == OP_REMU));

  // Bridges the cycles before the divider reports busy itself
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      div_pend_r <= 1'b0;
    end
    else if (disp_div)
    begin
      div_pend_r <= 1'b1;
    end
    else if (div_busy_i)
    begin
      div_pend_r <= 1'b0;
    end
  end

  a_single_divide: assert property (@(posedge clk_i) disable iff (rst_i)
    disp_div |-> !(div_pend_r || div_busy_i))
    else $error("divide dispatched while another divide is pending");

endmodule

`default_nettype wire

// ==== src/alu_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_pipe
(
  issue_if.dst            iss,
  output logic            alu_v_o,
  output calc_pkg::data_t alu_data_o
);
  import calc_pkg::*;

  // Result stays zero for ops served elsewhere so the stage 0 merge is a plain OR
  always_comb
  begin
    alu_v_o    = iss.v;
    alu_data_o = '0;
    case (iss.op)
      OP_ADD: alu_data_o = iss.rs1_data + iss.rs2_data;
      OP_SUB: alu_data_o = iss.rs1_data - iss.rs2_data;
      OP_AND: alu_data_o = iss.rs1_data & iss.rs2_data;
      OP_OR:  alu_data_o = iss.rs1_data | iss.rs2_data;
      OP_XOR: alu_data_o = iss.rs1_data ^ iss.rs2_data;
      OP_SLL: alu_data_o = iss.rs1_data << iss.rs2_data[SHAMT_W-1:0];
      OP_SRL: alu_data_o = iss.rs1_data >> iss.rs2_data[SHAMT_W-1:0];
      OP_SLT: alu_data_o = data_t'($signed(iss.rs1_data) < $signed(iss.rs2_data));
      default:
      begin
        alu_v_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_pipe
(
  input  logic            clk_i,
  input  logic            rst_i,
  issue_if.dst            iss,
  output logic            mul_v_o,
  output calc_pkg::data_t mul_data_o
);
  import calc_pkg::*;

  logic [MUL_STAGES-1:0] v_r;
  data_t                 lo_r;
  logic [XLEN/2-1:0]     cross_r;
  data_t                 prod_r;
  logic                  take;

  assign take = iss.v && (iss.op == OP_MUL);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_r <= '0;
    end
    else
    begin
      v_r <= {v_r[MUL_STAGES-2:0], take};
    end
  end

  // First stage forms the half products, high x high never reaches the low word
  always_ff @(posedge clk_i)
  begin
    lo_r    <= data_t'(iss.rs1_data[XLEN/2-1:0]) * data_t'(iss.rs2_data[XLEN/2-1:0]);
    cross_r <= iss.rs1_data[XLEN/2-1:0] * iss.rs2_data[XLEN-1:XLEN/2]
             + iss.rs1_data[XLEN-1:XLEN/2] * iss.rs2_data[XLEN/2-1:0];
    prod_r  <= lo_r + {cross_r, {(XLEN/2){1'b0}}};
  end

  assign mul_v_o    = v_r[MUL_STAGES-1];
  assign mul_data_o = prod_r;

endmodule

`default_nettype wire

// ==== src/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit
(
  input  logic   clk_i,
  input  logic   rst_i,
  issue_if.dst   iss,
  long_wb_if.src wb,
  output logic   div_ready_o,
  output logic   div_busy_o
);
  import calc_pkg::*;

  div_state_e           state_r;
  logic                 start;
  logic                 rem_sel_r;
  reg_addr_t            rd_r;
  data_t                dsr_r;
  data_t                quo_r;
  data_t                rem_r;
  data_t                res_r;
  logic [DIV_CNT_W-1:0] cnt_r;
  logic [XLEN:0]        shifted;
  logic [XLEN:0]        diff;
  logic                 fits;

  assign start = iss.v && ((iss.op == OP_DIVU) || (iss.op == OP_REMU));

  // Restoring step; a zero divisor always fits, giving all ones and rem = dividend
  assign shifted = {rem_r, quo_r[XLEN-1]};
  assign diff    = shifted - {1'b0, dsr_r};
  assign fits    = !diff[XLEN];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= DIV_IDLE;
    end
    else
    begin
      case (state_r)
        DIV_IDLE:
        begin
          if (start)
          begin
            state_r <= DIV_BUSY;
          end
        end
        DIV_BUSY:
        begin
          if (cnt_r == '0)
          begin
            state_r <= DIV_DONE;
          end
        end
        DIV_DONE:
        begin
          if (wb.yumi)
          begin
            state_r <= DIV_IDLE;
          end
        end
        default:
        begin
          state_r <= DIV_IDLE;
        end
      endcase
    end
  end

  // XLEN shift steps, then one cycle to latch the selected result
  always_ff @(posedge clk_i)
  begin
    if ((state_r == DIV_IDLE) && start)
    begin
      rd_r      <= iss.rd;
      rem_sel_r <= (iss.op == OP_REMU);
      quo_r     <= iss.rs1_data;
      dsr_r     <= iss.rs2_data;
      rem_r     <= '0;
      cnt_r     <= DIV_CNT_W'(XLEN);
    end
    else if (state_r == DIV_BUSY)
    begin
      if (cnt_r != '0)
      begin
        quo_r <= {quo_r[XLEN-2:0], fits};
        rem_r <= fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
        cnt_r <= cnt_r - DIV_CNT_W'(1);
      end
      else
      begin
        res_r <= rem_sel_r ? rem_r : quo_r;
      end
    end
  end

  assign wb.v    = (state_r == DIV_DONE);
  assign wb.rd   = rd_r;
  assign wb.data = res_r;

  // A divide waiting in the reservation register already counts as taken
  assign div_ready_o = (state_r == DIV_IDLE) && !start;
  assign div_busy_o  = (state_r != DIV_IDLE);

  a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    start |-> (state_r == DIV_IDLE))
    else $error("divide issued while the divider is occupied");

endmodule

`default_nettype wire

// ==== src/completion_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module completion_pipe
(
  input  logic                clk_i,
  input  logic                rst_i,
  issue_if.dst                iss,
  input  logic                alu_v_i,
  input  logic                mul_v_i,
  input  calc_pkg::data_t     alu_data_i,
  input  calc_pkg::data_t     mul_data_i,
  long_wb_if.dst              lwb,
  fwd_if.src                  fwd,
  output logic                wb_v_o,
  output calc_pkg::reg_addr_t wb_rd_o,
  output calc_pkg::data_t     wb_data_o
);
  import calc_pkg::*;

  logic      [COMP_STAGES-1:0] w_v_r;
  logic      [COMP_STAGES-1:0] w_v_n;
  logic      [COMP_STAGES-1:0] rdy_r;
  logic      [COMP_STAGES-1:0] rdy_n;
  reg_addr_t [COMP_STAGES-1:0] rd_r;
  reg_addr_t [COMP_STAGES-1:0] rd_n;
  data_t     [COMP_STAGES-1:0] data_r;
  data_t     [COMP_STAGES-1:0] data_n;
  logic                        iss_div;

  assign iss_div = (iss.op == OP_DIVU) || (iss.op == OP_REMU);

  // rdy marks entries whose result has already been merged
  always_comb
  begin
    w_v_n[0]  = iss.v && !iss_div && (iss.rd != '0);
    rdy_n[0]  = alu_v_i;
    rd_n[0]   = iss.rd;
    data_n[0] = alu_v_i ? alu_data_i : '0;
    for (int i = 1; i < COMP_STAGES; i++)
    begin
      w_v_n[i]  = w_v_r[i-1];
      rdy_n[i]  = rdy_r[i-1];
      rd_n[i]   = rd_r[i-1];
      data_n[i] = data_r[i-1];
    end
    rdy_n[MUL_STAGES]  = rdy_n[MUL_STAGES] | mul_v_i;
    data_n[MUL_STAGES] = data_n[MUL_STAGES] | (mul_v_i ? mul_data_i : '0);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      w_v_r <= '0;
      rdy_r <= '0;
    end
    else
    begin
      w_v_r <= w_v_n;
      rdy_r <= rdy_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_r   <= rd_n;
    data_r <= data_n;
  end

  assign fwd.v    = w_v_n & rdy_n;
  assign fwd.rd   = rd_n;
  assign fwd.data = data_n;

  // Divider only fills a slot the fixed pipe leaves empty
  assign lwb.yumi  = lwb.v && !w_v_r[COMP_STAGES-1];
  assign wb_v_o    = w_v_r[COMP_STAGES-1] || (lwb.yumi && (lwb.rd != '0));
  assign wb_rd_o   = lwb.yumi ? lwb.rd : rd_r[COMP_STAGES-1];
  assign wb_data_o = lwb.yumi ? lwb.data : data_r[COMP_STAGES-1];

  a_merge_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    mul_v_i |-> !rdy_r[MUL_STAGES-1])
    else $error("product merged onto an entry that holds an ALU result");

  a_wb_has_data: assert property (@(posedge clk_i) disable iff (rst_i)
    w_v_r[COMP_STAGES-1] |-> rdy_r[COMP_STAGES-1])
    else $error("writeback leaves the pipe without a result");

endmodule

`default_nettype wire

// ==== src/calc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module calc_top
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                dispatch_v_i,
  input  calc_pkg::op_e       dispatch_op_i,
  input  calc_pkg::reg_addr_t dispatch_rd_i,
  input  calc_pkg::reg_addr_t dispatch_rs1_addr_i,
  input  calc_pkg::reg_addr_t dispatch_rs2_addr_i,
  input  calc_pkg::data_t     dispatch_rs1_data_i,
  input  calc_pkg::data_t     dispatch_rs2_data_i,
  output logic                div_ready_o,
  output logic                wb_v_o,
  output calc_pkg::reg_addr_t wb_rd_o,
  output calc_pkg::data_t     wb_data_o
);
  import calc_pkg::*;

  logic  alu_v;
  data_t alu_data;
  logic  mul_v;
  data_t mul_data;
  logic  div_busy;

  issue_if   iss ();
  fwd_if     fwd ();
  long_wb_if lwb ();

  operand_bypass i_operand_bypass
  (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .dispatch_v_i        (dispatch_v_i),
    .dispatch_op_i       (dispatch_op_i),
    .dispatch_rd_i       (dispatch_rd_i),
    .dispatch_rs1_addr_i (dispatch_rs1_addr_i),
    .dispatch_rs2_addr_i (dispatch_rs2_addr_i),
    .dispatch_rs1_data_i (dispatch_rs1_data_i),
    .dispatch_rs2_data_i (dispatch_rs2_data_i),
    .div_busy_i          (div_busy),
    .fwd                 (fwd.dst),
    .iss                 (iss.src)
  );

  alu_pipe i_alu_pipe
  (
    .iss        (iss.dst),
    .alu_v_o    (alu_v),
    .alu_data_o (alu_data)
  );

  mul_pipe i_mul_pipe
  (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .iss        (iss.dst),
    .mul_v_o    (mul_v),
    .mul_data_o (mul_data)
  );

  div_unit i_div_unit
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .iss         (iss.dst),
    .wb          (lwb.src),
    .div_ready_o (div_ready_o),
    .div_busy_o  (div_busy)
  );

  completion_pipe i_completion_pipe
  (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .iss        (iss.dst),
    .alu_v_i    (alu_v),
    .mul_v_i    (mul_v),
    .alu_data_i (alu_data),
    .mul_data_i (mul_data),
    .lwb        (lwb.dst),
    .fwd        (fwd.src),
    .wb_v_o     (wb_v_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

`default_nettype wire

// ==== dv/calc_ref.svh ====
`ifndef CALC_REF_SVH
`define CALC_REF_SVH

// Instruction results worked out from the operation definitions
function automatic data_t ref_result(input op_e op, input data_t a, input data_t b);
  data_t r;
  case (op)
    OP_ADD:  r = a + b;
    OP_SUB:  r = a - b;
    OP_AND:  r = a & b;
    OP_OR:   r = a | b;
    OP_XOR:  r = a ^ b;
    OP_SLL:  r = a << b[4:0];
    OP_SRL:  r = a >> b[4:0];
    OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_MUL:  r = a * b;
    OP_DIVU: r = (b == 32'd0) ? 32'hffff_ffff : a / b;
    OP_REMU: r = (b == 32'd0) ? a : a % b;
    default: r = '0;
  endcase
  return r;
endfunction

function automatic logic is_div(input op_e op);
  return (op == OP_DIVU) || (op == OP_REMU);
endfunction

// Writebacks seen by the edge upto are in the register file
task automatic commit_due(input int upto);
  while ((pend_due.size() > 0) && (pend_due[0] <= upto))
  begin
    rf_commit[pend_rd[0]] = pend_val[0];
    void'(pend_due.pop_front());
    void'(pend_rd.pop_front());
    void'(pend_val.pop_front());
  end
endtask

task automatic expect_fixed(input int due, input reg_addr_t rd, input data_t val);
  pend_due.push_back(due);
  pend_rd.push_back(rd);
  pend_val.push_back(val);
  due_tag[due % 16]  <= due;
  due_rd[due % 16]   <= rd;
  due_data[due % 16] <= val;
endtask

`endif

// ==== dv/calc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
  import calc_pkg::*;

  localparam int RST_CYCLES = 16;
  localparam int N_IND = 40;
  localparam int N_CHAIN = 30;
  localparam int N_MUL = 8;
  localparam int N_DIV = 6;
  localparam int DIV_STREAM = 40;
  localparam int CYC_LIMIT = RST_CYCLES + N_IND + N_CHAIN + 4 * N_MUL
                           + N_DIV * (DIV_STREAM + XLEN + 8) + 64;

  logic      clk_i;
  logic      rst_i;
  logic      dispatch_v_i;
  op_e       dispatch_op_i;
  reg_addr_t dispatch_rd_i;
  reg_addr_t dispatch_rs1_addr_i;
  reg_addr_t dispatch_rs2_addr_i;
  data_t     dispatch_rs1_data_i;
  data_t     dispatch_rs2_data_i;
  logic      div_ready_o;
  logic      wb_v_o;
  reg_addr_t wb_rd_o;
  data_t     wb_data_o;

  data_t     rf_true [32];
  data_t     rf_commit [32];
  int        pend_due [$];
  reg_addr_t pend_rd [$];
  data_t     pend_val [$];
  int        due_tag [16];
  reg_addr_t due_rd [16];
  data_t     due_data [16];
  logic      exp_v;
  reg_addr_t exp_rd;
  data_t     exp_data;
  int        cyc = 0;
  int        seed = 1;
  int        div_issued = 0;
  int        div_done = 0;
  logic      div_held;
  logic      div_pend;
  reg_addr_t div_rd;
  data_t     div_data;
  int        val_err = 0;
  int        oth_err = 0;
  string     test_name = "reset";

  `include "calc_ref.svh"

  calc_top i_calc_top
  (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .dispatch_v_i        (dispatch_v_i),
    .dispatch_op_i       (dispatch_op_i),
    .dispatch_rd_i       (dispatch_rd_i),
    .dispatch_rs1_addr_i (dispatch_rs1_addr_i),
    .dispatch_rs2_addr_i (dispatch_rs2_addr_i),
    .dispatch_rs1_data_i (dispatch_rs1_data_i),
    .dispatch_rs2_data_i (dispatch_rs2_data_i),
    .div_ready_o         (div_ready_o),
    .wb_v_o              (wb_v_o),
    .wb_rd_o             (wb_rd_o),
    .wb_data_o           (wb_data_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Fixed-latency writeback expected in the cycle that ends at this edge
  assign exp_v    = (due_tag[cyc % 16] == cyc);
  assign exp_rd   = due_rd[cyc % 16];
  assign exp_data = due_data[cyc % 16];
  assign div_pend = (div_issued != div_done);

  // Cycle count, divider occupancy as seen from outside, and the run limit
  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
    if (rst_i)
    begin
      div_held <= 1'b0;
    end
    else if (dispatch_v_i && is_div(dispatch_op_i))
    begin
      div_held <= 1'b1;
    end
    else if (wb_v_o && !exp_v)
    begin
      div_held <= 1'b0;
      div_done <= div_done + 1;
    end
    if (cyc >= CYC_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYC_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  a_fixed_wb: assert property (@(posedge clk_i) disable iff (rst_i)
    exp_v |-> (wb_v_o && (wb_rd_o == exp_rd) && (wb_data_o == exp_data)))
    else
    begin
      val_err = val_err + 1;
      $display("Error %s: expected rd %0d data %h, actual v %b rd %0d data %h", test_name,
               $sampled(exp_rd), $sampled(exp_data), $sampled(wb_v_o), $sampled(wb_rd_o),
               $sampled(wb_data_o));
    end

  a_div_wb: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_v_o && !exp_v) |-> (div_pend && (wb_rd_o == div_rd) && (wb_data_o == div_data)))
    else
    begin
      val_err = val_err + 1;
      $display("Error %s: expected divide rd %0d data %h, actual rd %0d data %h", test_name,
               $sampled(div_rd), $sampled(div_data), $sampled(wb_rd_o), $sampled(wb_data_o));
    end

  a_div_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    div_ready_o == !div_held)
    else
    begin
      oth_err = oth_err + 1;
      $display("In %s div_ready_o does not follow the pending divide", test_name);
    end

  function automatic reg_addr_t rand_reg(input int lo, input int hi);
    return reg_addr_t'(lo + ($unsigned($random(seed)) % (hi - lo + 1)));
  endfunction

  function automatic op_e rand_alu_op();
    return op_e'($unsigned($random(seed)) % 8);
  endfunction

  // Register file data is stale and the DUT bypass fills in newer values
  task automatic dispatch(input op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                          input reg_addr_t rs2);
    data_t res;
    commit_due(cyc + 1);
    res = ref_result(op, rf_true[rs1], rf_true[rs2]);
    dispatch_v_i        <= 1'b1;
    dispatch_op_i       <= op;
    dispatch_rd_i       <= rd;
    dispatch_rs1_addr_i <= rs1;
    dispatch_rs2_addr_i <= rs2;
    dispatch_rs1_data_i <= rf_commit[rs1];
    dispatch_rs2_data_i <= rf_commit[rs2];
    if (is_div(op))
    begin
      div_rd     <= rd;
      div_data   <= res;
      div_issued <= div_issued + 1;
    end
    else if (rd != '0)
    begin
      rf_true[rd] = res;
      expect_fixed(cyc + 5, rd, res);
    end
    @(posedge clk_i);
  endtask

  task automatic idle();
    dispatch_v_i <= 1'b0;
    @(posedge clk_i);
  endtask

  initial
  begin
    reg_addr_t prev [3];
    reg_addr_t rd;
    for (int i = 0; i < 32; i++)
    begin
      rf_true[i]   = (i == 0) ? '0 : $random(seed);
      rf_commit[i] = rf_true[i];
    end
    for (int i = 0; i < 16; i++)
    begin
      due_tag[i] = -1;
    end
    rst_i               = 1'b1;
    dispatch_v_i        = 1'b0;
    dispatch_op_i       = OP_ADD;
    dispatch_rd_i       = '0;
    dispatch_rs1_addr_i = '0;
    dispatch_rs2_addr_i = '0;
    dispatch_rs1_data_i = '0;
    dispatch_rs2_data_i = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (4) idle();

    test_name = "alu_independent";
    for (int i = 0; i < N_IND; i++)
    begin
      dispatch(rand_alu_op(), rand_reg(0, 15), rand_reg(0, 15), rand_reg(0, 15));
    end

    test_name = "alu_chain";
    prev = '{5'd1, 5'd2, 5'd3};
    for (int i = 0; i < N_CHAIN; i++)
    begin
      rd = rand_reg(1, 15);
      dispatch(rand_alu_op(), rd, prev[rand_reg(0, 2)], prev[rand_reg(0, 2)]);
      prev[2] = prev[1];
      prev[1] = prev[0];
      prev[0] = rd;
    end

    // Dependent add goes out three edges after its multiply
    test_name = "multiply";
    for (int i = 0; i < N_MUL; i++)
    begin
      rd = rand_reg(1, 15);
      dispatch(OP_MUL, rd, rand_reg(0, 15), rand_reg(0, 15));
      idle();
      idle();
      dispatch(OP_ADD, rand_reg(1, 15), rd, rand_reg(0, 15));
    end

    // Register 0 as divisor gives the zero divide cases
    test_name = "divide";
    for (int i = 0; i < N_DIV; i++)
    begin
      while (div_pend)
      begin
        idle();
      end
      dispatch((i % 2 == 0) ? OP_DIVU : OP_REMU, rand_reg(16, 31), rand_reg(1, 15),
               (i < 2) ? 5'd0 : rand_reg(1, 15));
      for (int j = 0; j < DIV_STREAM; j++)
      begin
        dispatch(rand_alu_op(), (i >= 4) ? rand_reg(0, 15) : rand_reg(1, 15),
                 rand_reg(0, 15), rand_reg(0, 15));
      end
    end
    while (div_pend)
    begin
      idle();
    end
    repeat (8) idle();

    $display("Checks done: %0d value errors, %0d other errors", val_err, oth_err);
    if ((val_err + oth_err) == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+dv
src/calc_pkg.sv
src/calc_ifs.sv
src/operand_bypass.sv
src/alu_pipe.sv
src/mul_pipe.sv
src/div_unit.sv
src/completion_pipe.sv
src/calc_top.sv
dv/calc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       ?= calc_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
